// File: include/regbank_macros.svh
`ifndef REGBANK_MACROS_SVH
`define REGBANK_MACROS_SVH

// Width of one register word.
`define REG_DATA_W 32

// Writable parameter words, mapped from address 0 upwards.
`define N_PARAM 2

// Read-only status words, mapped right after the parameter words.
`define N_STATUS 1

// Register address width, 8 word slots.
`define REG_ADDR_W 3

// Flip-flops in each synchronizer chain.
`define SYNC_STAGES 2

`endif

// File: hdl/regbank_pkg.sv
`include "regbank_macros.svh"

package regbank_pkg;

	typedef enum logic {
		op_read  = 1'b0,
		op_write = 1'b1
	} reg_op_e;

	// Source side of the CDC handshake.
	typedef enum logic {
		hsk_idle     = 1'b0, // Latch new data and toggle the request.
		hsk_wait_ack = 1'b1  // Data in flight, held stable.
	} hsk_state_e;

	// Word i sits at bits [i*REG_DATA_W +: REG_DATA_W].
	typedef logic [`N_PARAM*`REG_DATA_W-1:0] param_vec_t;
	typedef logic [`N_STATUS*`REG_DATA_W-1:0] status_vec_t;

endpackage

// File: hdl/repeating_handshake.sv
`include "regbank_macros.svh"

module repeating_handshake #(
	parameter int WIDTH = 64
) (
	input  logic             src_clk,
	input  logic             dest_clk,
	input  logic             rst,
	input  logic [WIDTH-1:0] src_data,
	output logic [WIDTH-1:0] dest_data
);

	import regbank_pkg::*;

	hsk_state_e state;
	logic req; // Toggles once per transfer.
	logic [WIDTH-1:0] src_hold;
	logic [`SYNC_STAGES-1:0] ack_sync;
	logic [`SYNC_STAGES-1:0] req_sync;
	logic req_seen; // Last request level taken by the destination.
	logic ack_done;
	logic req_new;

	assign ack_done = (ack_sync[`SYNC_STAGES-1] == req);
	assign req_new = (req_sync[`SYNC_STAGES-1] != req_seen);

	// Source domain.
	always_ff @(posedge src_clk) begin
		if (rst) begin
			state <= hsk_idle;
			req <= 1'b0;
		end else begin
			case (state)
				hsk_idle: begin
					req <= ~req;
					state <= hsk_wait_ack;
				end
				hsk_wait_ack: begin
					if (ack_done) begin
						state <= hsk_idle;
					end
				end
				default: begin
					state <= hsk_idle;
				end
			endcase
		end
	end

	// Loaded on the same edge the request toggles, then frozen until acked.
	always_ff @(posedge src_clk) begin
		if (state == hsk_idle) begin
			src_hold <= src_data;
		end
	end

	always_ff @(posedge src_clk) begin
		if (rst) begin
			ack_sync <= '0;
		end else begin
			ack_sync <= {ack_sync[`SYNC_STAGES-2:0], req_seen};
		end
	end

	// Destination domain.
	always_ff @(posedge dest_clk) begin
		if (rst) begin
			req_sync <= '0;
			req_seen <= 1'b0;
		end else begin
			req_sync <= {req_sync[`SYNC_STAGES-2:0], req};
			req_seen <= req_sync[`SYNC_STAGES-1]; // Doubles as the acknowledge.
		end
	end

	always_ff @(posedge dest_clk) begin
		if (rst) begin
			dest_data <= '0;
		end else if (req_new) begin
			dest_data <= src_hold; // Stable since the toggle, safe to sample.
		end
	end

endmodule

// File: hdl/reg_arbiter.sv
`include "regbank_macros.svh"

module reg_arbiter (
	input  logic                   src_clk,
	input  logic                   rst,
	input  logic                   host_valid,
	output logic                   host_ready,
	input  regbank_pkg::reg_op_e   host_op,
	input  logic [`REG_ADDR_W-1:0] host_addr,
	input  logic [`REG_DATA_W-1:0] host_wdata,
	output logic                   host_rsp_valid,
	output logic [`REG_DATA_W-1:0] host_rsp_rdata,
	input  logic                   debug_valid,
	output logic                   debug_ready,
	input  regbank_pkg::reg_op_e   debug_op,
	input  logic [`REG_ADDR_W-1:0] debug_addr,
	input  logic [`REG_DATA_W-1:0] debug_wdata,
	output logic                   debug_rsp_valid,
	output logic [`REG_DATA_W-1:0] debug_rsp_rdata,
	output logic                   req_valid,
	output regbank_pkg::reg_op_e   req_op,
	output logic [`REG_ADDR_W-1:0] req_addr,
	output logic [`REG_DATA_W-1:0] req_wdata,
	input  logic                   rsp_valid,
	input  logic [`REG_DATA_W-1:0] rsp_rdata
);

	import regbank_pkg::*;

	logic grant_host;
	logic grant_debug;
	logic last_debug;  // Debug port won the last grant.
	logic owner_debug; // Response in flight belongs to debug.

	// Round robin, the port that did not win last time goes first.
	always_comb begin
		grant_host = host_valid && (!debug_valid || last_debug);
		grant_debug = debug_valid && (!host_valid || !last_debug);
	end

	assign host_ready = grant_host;
	assign debug_ready = grant_debug;

	assign req_valid = grant_host || grant_debug;
	assign req_op = grant_debug ? debug_op : host_op;
	assign req_addr = grant_debug ? debug_addr : host_addr;
	assign req_wdata = grant_debug ? debug_wdata : host_wdata;

	always_ff @(posedge src_clk) begin
		if (rst) begin
			last_debug <= 1'b0;
			owner_debug <= 1'b0;
		end else begin
			if (req_valid) begin
				last_debug <= grant_debug;
			end
			owner_debug <= grant_debug; // Register file answers one cycle later.
		end
	end

	// Only the owner sees the response.
	assign host_rsp_valid = rsp_valid && !owner_debug;
	assign debug_rsp_valid = rsp_valid && owner_debug;
	assign host_rsp_rdata = owner_debug ? '0 : rsp_rdata;
	assign debug_rsp_rdata = owner_debug ? rsp_rdata : '0;

endmodule

// File: hdl/reg_file.sv
`include "regbank_macros.svh"

module reg_file (
	input  logic                     src_clk,
	input  logic                     rst,
	input  logic                     req_valid,
	input  regbank_pkg::reg_op_e     req_op,
	input  logic [`REG_ADDR_W-1:0]   req_addr,
	input  logic [`REG_DATA_W-1:0]   req_wdata,
	output logic                     rsp_valid,
	output logic [`REG_DATA_W-1:0]   rsp_rdata,
	output regbank_pkg::param_vec_t  param_out,
	input  regbank_pkg::status_vec_t status_in
);

	import regbank_pkg::*;

	logic [`REG_DATA_W-1:0] param_q [`N_PARAM];
	logic [`N_PARAM-1:0] wr_en;
	logic [`REG_DATA_W-1:0] rd_word;

	// Write decode, only the parameter words are writable.
	always_comb begin
		wr_en = '0;
		for (int i = 0; i < `N_PARAM; i++) begin
			if (req_valid && req_op == op_write && req_addr == `REG_ADDR_W'(i)) begin
				wr_en[i] = 1'b1;
			end
		end
	end

	// Read mux, unmapped addresses read as zero.
	always_comb begin
		rd_word = '0;
		for (int i = 0; i < `N_PARAM; i++) begin
			if (req_addr == `REG_ADDR_W'(i)) begin
				rd_word = param_q[i];
			end
		end
		for (int i = 0; i < `N_STATUS; i++) begin
			if (req_addr == `REG_ADDR_W'(`N_PARAM + i)) begin
				rd_word = status_in[i*`REG_DATA_W +: `REG_DATA_W];
			end
		end
	end

	always_ff @(posedge src_clk) begin
		if (rst) begin
			for (int i = 0; i < `N_PARAM; i++) begin
				param_q[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `N_PARAM; i++) begin
				if (wr_en[i]) begin
					param_q[i] <= req_wdata;
				end
			end
		end
	end

	// Every request gets a response, writes return zero.
	always_ff @(posedge src_clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
			rsp_rdata <= '0;
		end else begin
			rsp_valid <= req_valid;
			rsp_rdata <= (req_valid && req_op == op_read) ? rd_word : '0;
		end
	end

	always_comb begin
		for (int i = 0; i < `N_PARAM; i++) begin
			param_out[i*`REG_DATA_W +: `REG_DATA_W] = param_q[i];
		end
	end

endmodule

// File: hdl/ip_compute.sv
`include "regbank_macros.svh"

module ip_compute (
	input  logic                     dest_clk,
	input  logic                     rst,
	input  regbank_pkg::param_vec_t  ip_params,
	output regbank_pkg::status_vec_t ip_status
);

	import regbank_pkg::*;

	logic [`REG_DATA_W-1:0] sum;

	// Wraps modulo 2^REG_DATA_W.
	always_comb begin
		sum = '0;
		for (int i = 0; i < `N_PARAM; i++) begin
			sum = sum + ip_params[i*`REG_DATA_W +: `REG_DATA_W];
		end
	end

	// Sum goes to status word 0, any further words stay zero.
	always_ff @(posedge dest_clk) begin
		if (rst) begin
			ip_status <= '0;
		end else begin
			ip_status <= status_vec_t'(sum);
		end
	end

endmodule

// File: hdl/regbank_top.sv
`include "regbank_macros.svh"

module regbank_top (
	input  logic                    src_clk,
	input  logic                    dest_clk,
	input  logic                    rst,
	input  logic                    host_valid,
	output logic                    host_ready,
	input  regbank_pkg::reg_op_e    host_op,
	input  logic [`REG_ADDR_W-1:0]  host_addr,
	input  logic [`REG_DATA_W-1:0]  host_wdata,
	output logic                    host_rsp_valid,
	output logic [`REG_DATA_W-1:0]  host_rsp_rdata,
	input  logic                    debug_valid,
	output logic                    debug_ready,
	input  regbank_pkg::reg_op_e    debug_op,
	input  logic [`REG_ADDR_W-1:0]  debug_addr,
	input  logic [`REG_DATA_W-1:0]  debug_wdata,
	output logic                    debug_rsp_valid,
	output logic [`REG_DATA_W-1:0]  debug_rsp_rdata,
	output regbank_pkg::param_vec_t ip_params
);

	import regbank_pkg::*;

	logic req_valid;
	reg_op_e req_op;
	logic [`REG_ADDR_W-1:0] req_addr;
	logic [`REG_DATA_W-1:0] req_wdata;
	logic rsp_valid;
	logic [`REG_DATA_W-1:0] rsp_rdata;
	param_vec_t param_out;
	status_vec_t status_in;
	status_vec_t ip_status;

	reg_arbiter i_reg_arbiter (
		.src_clk         (src_clk),
		.rst             (rst),
		.host_valid      (host_valid),
		.host_ready      (host_ready),
		.host_op         (host_op),
		.host_addr       (host_addr),
		.host_wdata      (host_wdata),
		.host_rsp_valid  (host_rsp_valid),
		.host_rsp_rdata  (host_rsp_rdata),
		.debug_valid     (debug_valid),
		.debug_ready     (debug_ready),
		.debug_op        (debug_op),
		.debug_addr      (debug_addr),
		.debug_wdata     (debug_wdata),
		.debug_rsp_valid (debug_rsp_valid),
		.debug_rsp_rdata (debug_rsp_rdata),
		.req_valid       (req_valid),
		.req_op          (req_op),
		.req_addr        (req_addr),
		.req_wdata       (req_wdata),
		.rsp_valid       (rsp_valid),
		.rsp_rdata       (rsp_rdata)
	);

	reg_file i_reg_file (
		.src_clk   (src_clk),
		.rst       (rst),
		.req_valid (req_valid),
		.req_op    (req_op),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.rsp_valid (rsp_valid),
		.rsp_rdata (rsp_rdata),
		.param_out (param_out),
		.status_in (status_in)
	);

	// Bus to IP.
	repeating_handshake #(
		.WIDTH ($bits(param_vec_t))
	) i_param_sync (
		.src_clk   (src_clk),
		.dest_clk  (dest_clk),
		.rst       (rst),
		.src_data  (param_out),
		.dest_data (ip_params)
	);

	ip_compute i_ip_compute (
		.dest_clk  (dest_clk),
		.rst       (rst),
		.ip_params (ip_params),
		.ip_status (ip_status)
	);

	// IP back to bus, clocks swapped.
	repeating_handshake #(
		.WIDTH ($bits(status_vec_t))
	) i_status_sync (
		.src_clk   (dest_clk),
		.dest_clk  (src_clk),
		.rst       (rst),
		.src_data  (ip_status),
		.dest_data (status_in)
	);

endmodule

// File: verification/regbank_tb.sv
`include "regbank_macros.svh"

module regbank_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import regbank_pkg::*;

	localparam int SRC_PERIOD = 10;
	localparam int DEST_POLL_BOUND = 40; // dest_clk cycles for ip_params to settle.
	localparam int SRC_POLL_BOUND = 60;  // src_clk cycles for the status round trip.

	typedef struct {
		logic                   is_debug;
		reg_op_e                op;
		logic [`REG_ADDR_W-1:0] addr;
		logic [`REG_DATA_W-1:0] wdata;
		logic [`REG_DATA_W-1:0] exp;
		param_vec_t             exp_params; // Parameter words after this entry.
		logic                   poll;       // Repeat the read until exp shows up.
		logic                   with_next;  // Issued in the same cycle as the next entry.
	} entry_t;

	logic src_clk = 1'b0;
	logic dest_clk = 1'b0;
	logic rst;
	logic host_valid;
	logic host_ready;
	reg_op_e host_op;
	logic [`REG_ADDR_W-1:0] host_addr;
	logic [`REG_DATA_W-1:0] host_wdata;
	logic host_rsp_valid;
	logic [`REG_DATA_W-1:0] host_rsp_rdata;
	logic debug_valid;
	logic debug_ready;
	reg_op_e debug_op;
	logic [`REG_ADDR_W-1:0] debug_addr;
	logic [`REG_DATA_W-1:0] debug_wdata;
	logic debug_rsp_valid;
	logic [`REG_DATA_W-1:0] debug_rsp_rdata;
	param_vec_t ip_params;

	entry_t table_q [$];
	param_vec_t history_q [$]; // Every value the parameter words have held.
	logic [`REG_DATA_W-1:0] model [`N_PARAM];
	int seed = 32'hdc71;
	int n_entries = 0;
	int src_cycles = 0;
	int checks = 0;
	int errors = 0;
	logic host_pending = 1'b0;
	logic debug_pending = 1'b0;
	logic last_grant_debug = 1'b0;
	logic grant_seen = 1'b0;
	param_vec_t last_ip_params = '0;

	regbank_top i_regbank_top (
		.src_clk         (src_clk),
		.dest_clk        (dest_clk),
		.rst             (rst),
		.host_valid      (host_valid),
		.host_ready      (host_ready),
		.host_op         (host_op),
		.host_addr       (host_addr),
		.host_wdata      (host_wdata),
		.host_rsp_valid  (host_rsp_valid),
		.host_rsp_rdata  (host_rsp_rdata),
		.debug_valid     (debug_valid),
		.debug_ready     (debug_ready),
		.debug_op        (debug_op),
		.debug_addr      (debug_addr),
		.debug_wdata     (debug_wdata),
		.debug_rsp_valid (debug_rsp_valid),
		.debug_rsp_rdata (debug_rsp_rdata),
		.ip_params       (ip_params)
	);

	always #4 dest_clk = ~dest_clk;
	always #(SRC_PERIOD / 2) src_clk = ~src_clk;

	always @(posedge src_clk) begin
		src_cycles <= src_cycles + 1;
	end

	task automatic check_value(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Error at %0t: %s expected 0x%0h, actual 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	// Expected data follows the address map of params, then status, then zeros.
	task automatic add_entry(input logic is_debug, input reg_op_e op, input int addr,
			input logic poll, input logic with_next);
		entry_t e;
		e.is_debug = is_debug;
		e.op = op;
		e.addr = addr[`REG_ADDR_W-1:0];
		e.wdata = '0;
		e.exp = '0;
		e.poll = poll;
		e.with_next = with_next;
		if (op == op_write) begin
			e.wdata = $random(seed);
			if (addr < `N_PARAM) begin
				model[addr] = e.wdata;
				history_q.push_back({model[1], model[0]});
			end
		end else if (addr < `N_PARAM) begin
			e.exp = model[addr];
		end else if (addr < `N_PARAM + `N_STATUS) begin
			e.exp = model[0] + model[1]; // Wraps at 32 bits.
		end
		e.exp_params = {model[1], model[0]};
		table_q.push_back(e);
	endtask

	task automatic build_table();
		model[0] = '0;
		model[1] = '0;
		history_q.push_back('0);
		add_entry(1'b0, op_read, 0, 1'b0, 1'b0); // Reset values.
		add_entry(1'b0, op_read, 1, 1'b0, 1'b0);
		add_entry(1'b0, op_read, 2, 1'b0, 1'b0);
		add_entry(1'b0, op_write, 0, 1'b0, 1'b0);
		add_entry(1'b0, op_write, 1, 1'b0, 1'b0);
		add_entry(1'b0, op_read, 0, 1'b0, 1'b0);
		add_entry(1'b0, op_read, 1, 1'b0, 1'b0);
		for (int a = 3; a < 8; a++) begin
			add_entry(1'b0, op_read, a, 1'b0, 1'b0);
		end
		add_entry(1'b0, op_write, 2, 1'b0, 1'b0); // Read-only word drops the write.
		add_entry(1'b0, op_read, 2, 1'b1, 1'b0);
		add_entry(1'b1, op_write, 0, 1'b0, 1'b0);
		add_entry(1'b1, op_read, 0, 1'b0, 1'b0);
		add_entry(1'b1, op_write, 1, 1'b0, 1'b0);
		add_entry(1'b1, op_read, 1, 1'b0, 1'b0);
		add_entry(1'b1, op_read, 5, 1'b0, 1'b0);
		add_entry(1'b1, op_read, 2, 1'b1, 1'b0);
		// Contended pairs never touch the word the partner reads.
		repeat (2) begin
			add_entry(1'b0, op_read, 0, 1'b0, 1'b1);
			add_entry(1'b1, op_read, 1, 1'b0, 1'b0);
		end
		add_entry(1'b0, op_read, 0, 1'b0, 1'b0); // Host wins alone, debug is next in line.
		add_entry(1'b1, op_read, 0, 1'b0, 1'b1);
		add_entry(1'b0, op_read, 1, 1'b0, 1'b0);
		add_entry(1'b0, op_write, 0, 1'b0, 1'b1);
		add_entry(1'b1, op_read, 1, 1'b0, 1'b0);
		add_entry(1'b1, op_write, 1, 1'b0, 1'b1);
		add_entry(1'b0, op_read, 0, 1'b0, 1'b0);
		add_entry(1'b1, op_read, 0, 1'b0, 1'b0);
		add_entry(1'b0, op_read, 2, 1'b1, 1'b0);
		n_entries = table_q.size();
	endtask

	task automatic drive_port(input logic is_debug, input logic valid, input reg_op_e op,
			input logic [`REG_ADDR_W-1:0] addr, input logic [`REG_DATA_W-1:0] wdata);
		if (is_debug) begin
			debug_valid = valid;
			debug_op = op;
			debug_addr = addr;
			debug_wdata = wdata;
		end else begin
			host_valid = valid;
			host_op = op;
			host_addr = addr;
			host_wdata = wdata;
		end
	endtask

	// Holds the request until ready, then takes the response one cycle later.
	task automatic run_request(input entry_t e, output logic [`REG_DATA_W-1:0] rdata);
		@(posedge src_clk);
		#1;
		drive_port(e.is_debug, 1'b1, e.op, e.addr, e.wdata);
		do begin
			@(negedge src_clk);
		end while (!(e.is_debug ? debug_ready : host_ready));
		@(posedge src_clk);
		#1;
		drive_port(e.is_debug, 1'b0, op_read, '0, '0);
		@(negedge src_clk);
		rdata = e.is_debug ? debug_rsp_rdata : host_rsp_rdata;
	endtask

	task automatic apply_entry(input entry_t e);
		logic [`REG_DATA_W-1:0] rdata;
		run_request(e, rdata);
		check_value(e.is_debug ? "debug_rsp_rdata" : "host_rsp_rdata", e.exp, rdata);
	endtask

	task automatic poll_status(input entry_t e);
		int waited;
		int start;
		logic matched;
		logic [`REG_DATA_W-1:0] rdata;
		waited = 0;
		while (ip_params !== e.exp_params && waited < DEST_POLL_BOUND) begin
			@(negedge dest_clk);
			waited++;
		end
		check_value("ip_params", e.exp_params, ip_params);
		start = src_cycles;
		matched = 1'b0;
		while (!matched && src_cycles - start < SRC_POLL_BOUND) begin
			run_request(e, rdata);
			matched = (rdata === e.exp);
		end
		if (!matched) begin
			check_value(e.is_debug ? "debug_rsp_rdata" : "host_rsp_rdata", e.exp, rdata);
		end
	endtask

	function automatic logic in_history(input param_vec_t v);
		foreach (history_q[k]) begin
			if (history_q[k] === v) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	// Response routing and round-robin order.
	always @(negedge src_clk) begin
		if (rst) begin
			host_pending = 1'b0;
			debug_pending = 1'b0;
			grant_seen = 1'b0;
		end else begin
			check_value("host_rsp_valid", host_pending, host_rsp_valid);
			check_value("debug_rsp_valid", debug_pending, debug_rsp_valid);
			if (host_ready && debug_ready) begin
				errors++;
				$display("Both ports were granted in the same cycle at %0t", $time);
			end
			if (host_valid && debug_valid && (host_ready || debug_ready) && grant_seen &&
					debug_ready == last_grant_debug) begin
				errors++;
				$display("Contended grant at %0t went to the same port twice", $time);
			end
			if ((host_valid && host_ready) || (debug_valid && debug_ready)) begin
				last_grant_debug = debug_valid && debug_ready;
				grant_seen = 1'b1;
			end
			host_pending = host_valid && host_ready;
			debug_pending = debug_valid && debug_ready;
		end
	end

	always @(negedge dest_clk) begin
		if (!rst && ip_params !== last_ip_params) begin
			if (!in_history(ip_params)) begin
				errors++;
				$display("ip_params took a mixed value 0x%0h at %0t", ip_params, $time);
			end
			last_ip_params = ip_params;
		end
	end

	initial begin
		wait (n_entries > 0);
		#(n_entries * SRC_POLL_BOUND * SRC_PERIOD);
		$display("Timeout, the stimulus table did not finish after %0d ns",
			n_entries * SRC_POLL_BOUND * SRC_PERIOD);
		$display("Something failed");
		$finish;
	end

	initial begin
		$timeformat(-9, 1, " ns", 0);
		rst = 1'b1;
		drive_port(1'b0, 1'b0, op_read, '0, '0);
		drive_port(1'b1, 1'b0, op_read, '0, '0);
		build_table();
		repeat (3) @(posedge dest_clk);
		@(posedge src_clk);
		#1;
		rst = 1'b0;
		@(negedge dest_clk);
		check_value("ip_params", '0, ip_params);
		for (int i = 0; i < n_entries; i++) begin
			if (table_q[i].poll) begin
				poll_status(table_q[i]);
			end else if (table_q[i].with_next) begin
				fork
					apply_entry(table_q[i]);
					apply_entry(table_q[i + 1]);
				join
				i++;
			end else begin
				apply_entry(table_q[i]);
			end
		end
		repeat (2) @(negedge src_clk);
		$display("Ran %0d table entries: %0d checks, %0d errors", n_entries, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// File: verilog.f
+incdir+include
hdl/regbank_pkg.sv
hdl/repeating_handshake.sv
hdl/reg_arbiter.sv
hdl/reg_file.sv
hdl/ip_compute.sv
hdl/regbank_top.sv
verification/regbank_tb.sv

// File: Bender.yml
package:
  name: regbank

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/regbank_pkg.sv
      - hdl/repeating_handshake.sv
      - hdl/reg_arbiter.sv
      - hdl/reg_file.sv
      - hdl/ip_compute.sv
      - hdl/regbank_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/regbank_tb.sv
